/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;

    typedef enum logic [3:0] {
        op_illegal,
        op_addi,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lui,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal
    } op_kind_e;

    typedef enum logic [1:0] {
        st_idle,
        st_execute,
        st_mem_wait,
        st_writeback
    } exec_state_e;

    // wishbone classic master side
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [xlen-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_word_t;

    typedef struct packed {
        logic valid;
        logic we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [reg_addr_w-1:0] rd;
    } mem_op_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       rd_data
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

    // x0 never written and stays zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**rv_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::redirect_t   redirect,
    output rv_pkg::fetch_word_t fetch_word,
    input  logic                take,
    output rv_pkg::wb_req_t     fetch_req,
    input  rv_pkg::wb_rsp_t     fetch_rsp
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] req_adr;
    logic busy;
    logic discard;
    logic taken;
    logic can_issue;
    rv_pkg::fetch_word_t word_q;

    assign taken = word_q.valid && take;
    // buffer empty or emptying this cycle
    assign can_issue = !busy && (!word_q.valid || taken) && !redirect.valid;

    assign fetch_word = word_q;

    always_comb begin
        fetch_req.cyc = busy;
        fetch_req.stb = busy;
        fetch_req.we = 1'b0;
        fetch_req.adr = req_adr;
        fetch_req.dat_w = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::reset_pc;
            busy <= 1'b0;
            discard <= 1'b0;
            word_q.valid <= 1'b0;
        end else begin
            if (taken) begin
                word_q.valid <= 1'b0;
            end
            if (busy && fetch_rsp.ack) begin
                busy <= 1'b0;
                discard <= 1'b0;
                if (!discard && !redirect.valid) begin
                    word_q.valid <= 1'b1;
                    word_q.pc <= req_adr;
                    word_q.instr <= fetch_rsp.dat_r;
                    pc <= pc + 32'd4;
                end
            end else if (can_issue) begin
                busy <= 1'b1;
                req_adr <= pc;
            end
            // flush drops the buffer and marks the word in flight as stale
            if (redirect.valid) begin
                word_q.valid <= 1'b0;
                pc <= redirect.target;
                if (busy && !fetch_rsp.ack) begin
                    discard <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::fetch_word_t     fetch_word,
    output logic                    take,
    output rv_pkg::redirect_t       redirect,
    output rv_pkg::mem_op_t         mem_op,
    input  logic                    mem_done,
    input  logic [rv_pkg::xlen-1:0] load_data
);

    rv_pkg::exec_state_e state;
    rv_pkg::op_kind_e op;
    logic [rv_pkg::xlen-1:0] pc_q;
    logic [rv_pkg::xlen-1:0] instr_q;
    logic [rv_pkg::xlen-1:0] result_q;
    logic wr_en_q;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic [rv_pkg::xlen-1:0] alu_res;
    logic is_mem;
    logic writes_rd;
    logic jump;

    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        op = rv_pkg::op_illegal;
        case (instr_q[6:0])
            rv_pkg::opc_op_imm: begin
                if (instr_q[14:12] == 3'b000) op = rv_pkg::op_addi;
            end
            rv_pkg::opc_op: begin
                if (instr_q[31:25] == 7'b0000000) begin
                    case (instr_q[14:12])
                        3'b000: op = rv_pkg::op_add;
                        3'b111: op = rv_pkg::op_and;
                        3'b110: op = rv_pkg::op_or;
                        3'b100: op = rv_pkg::op_xor;
                        default: op = rv_pkg::op_illegal;
                    endcase
                end else if (instr_q[31:25] == 7'b0100000 && instr_q[14:12] == 3'b000) begin
                    op = rv_pkg::op_sub;
                end
            end
            rv_pkg::opc_lui: op = rv_pkg::op_lui;
            rv_pkg::opc_load: begin
                if (instr_q[14:12] == 3'b010) op = rv_pkg::op_lw;
            end
            rv_pkg::opc_store: begin
                if (instr_q[14:12] == 3'b010) op = rv_pkg::op_sw;
            end
            rv_pkg::opc_branch: begin
                if (instr_q[14:12] == 3'b000) op = rv_pkg::op_beq;
                else if (instr_q[14:12] == 3'b001) op = rv_pkg::op_bne;
            end
            rv_pkg::opc_jal: op = rv_pkg::op_jal;
            default: op = rv_pkg::op_illegal;
        endcase
    end

    always_comb begin
        case (op)
            rv_pkg::op_addi: alu_res = rs1_data + imm_i;
            rv_pkg::op_add: alu_res = rs1_data + rs2_data;
            rv_pkg::op_sub: alu_res = rs1_data - rs2_data;
            rv_pkg::op_and: alu_res = rs1_data & rs2_data;
            rv_pkg::op_or: alu_res = rs1_data | rs2_data;
            rv_pkg::op_xor: alu_res = rs1_data ^ rs2_data;
            rv_pkg::op_lui: alu_res = imm_u;
            // link value
            rv_pkg::op_jal: alu_res = pc_q + 32'd4;
            default: alu_res = '0;
        endcase
    end

    assign is_mem = (op == rv_pkg::op_lw) || (op == rv_pkg::op_sw);
    assign writes_rd = (op != rv_pkg::op_illegal) && (op != rv_pkg::op_sw) &&
                       (op != rv_pkg::op_beq) && (op != rv_pkg::op_bne);
    assign jump = (op == rv_pkg::op_jal) ||
                  (op == rv_pkg::op_beq && rs1_data == rs2_data) ||
                  (op == rv_pkg::op_bne && rs1_data != rs2_data);

    assign take = (state == rv_pkg::st_idle);

    always_comb begin
        redirect.valid = (state == rv_pkg::st_execute) && jump;
        redirect.target = pc_q + ((op == rv_pkg::op_jal) ? imm_j : imm_b);
        mem_op.valid = (state == rv_pkg::st_execute) && is_mem;
        mem_op.we = (op == rv_pkg::op_sw);
        mem_op.addr = rs1_data + ((op == rv_pkg::op_sw) ? imm_s : imm_i);
        mem_op.wdata = rs2_data;
        mem_op.rd = instr_q[11:7];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::st_idle;
            wr_en_q <= 1'b0;
        end else begin
            case (state)
                rv_pkg::st_idle: begin
                    if (fetch_word.valid) state <= rv_pkg::st_execute;
                end
                rv_pkg::st_execute: begin
                    wr_en_q <= writes_rd;
                    state <= is_mem ? rv_pkg::st_mem_wait : rv_pkg::st_writeback;
                end
                rv_pkg::st_mem_wait: begin
                    if (mem_done) state <= rv_pkg::st_writeback;
                end
                default: state <= rv_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_pkg::st_idle && fetch_word.valid) begin
            pc_q <= fetch_word.pc;
            instr_q <= fetch_word.instr;
        end
        if (state == rv_pkg::st_execute) begin
            result_q <= alu_res;
        end else if (state == rv_pkg::st_mem_wait && mem_done && op == rv_pkg::op_lw) begin
            result_q <= load_data;
        end
    end

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (instr_q[19:15]),
        .rs2      (instr_q[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (state == rv_pkg::st_writeback && wr_en_q),
        .rd       (instr_q[11:7]),
        .rd_data  (result_q)
    );

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::mem_op_t         mem_op,
    output logic                    mem_done,
    output logic [rv_pkg::xlen-1:0] load_data,
    output rv_pkg::wb_req_t         data_req,
    input  rv_pkg::wb_rsp_t         data_rsp
);

    // op_q.valid doubles as the busy flag
    rv_pkg::mem_op_t op_q;
    logic ack;

    assign ack = op_q.valid && data_rsp.ack;

    always_comb begin
        data_req.cyc = op_q.valid;
        data_req.stb = op_q.valid;
        data_req.we = op_q.we;
        data_req.adr = op_q.addr;
        data_req.dat_w = op_q.wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_q.valid <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= ack;
            if (ack) begin
                op_q.valid <= 1'b0;
            end else if (!op_q.valid && mem_op.valid) begin
                op_q <= mem_op;
            end
        end
    end

    // read data captured on ack
    always_ff @(posedge clk) begin
        if (ack && !op_q.we) begin
            load_data <= data_rsp.dat_r;
        end
    end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::wb_req_t fetch_req,
    output rv_pkg::wb_rsp_t fetch_rsp,
    input  rv_pkg::wb_req_t data_req,
    output rv_pkg::wb_rsp_t data_rsp,
    output rv_pkg::wb_req_t bus_req,
    input  rv_pkg::wb_rsp_t bus_rsp
);

    // owner_data_q is 1 when the data master held the bus last cycle
    logic owner_data_q;
    logic locked_q;
    logic owner_busy;
    logic sel_data;

    // the owner keeps the bus until its cyc falls
    assign owner_busy = locked_q && (owner_data_q ? data_req.cyc : fetch_req.cyc);

    // otherwise data wins when both are pending
    assign sel_data = owner_busy ? owner_data_q : data_req.cyc;

    assign bus_req = sel_data ? data_req : fetch_req;

    always_comb begin
        fetch_rsp.dat_r = bus_rsp.dat_r;
        data_rsp.dat_r = bus_rsp.dat_r;
        fetch_rsp.ack = bus_rsp.ack && !sel_data;
        data_rsp.ack = bus_rsp.ack && sel_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked_q <= 1'b0;
            owner_data_q <= 1'b0;
        end else begin
            locked_q <= bus_req.cyc;
            owner_data_q <= sel_data;
        end
    end

endmodule

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::wb_req_t bus_req,
    input  rv_pkg::wb_rsp_t bus_rsp
);

    rv_pkg::wb_req_t fetch_req;
    rv_pkg::wb_rsp_t fetch_rsp;
    rv_pkg::wb_req_t data_req;
    rv_pkg::wb_rsp_t data_rsp;
    rv_pkg::fetch_word_t fetch_word;
    rv_pkg::redirect_t redirect;
    rv_pkg::mem_op_t mem_op;
    logic take;
    logic mem_done;
    logic [rv_pkg::xlen-1:0] load_data;

    fetch_unit fetch_unit_i (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .fetch_word (fetch_word),
        .take       (take),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .reset      (reset),
        .fetch_word (fetch_word),
        .take       (take),
        .redirect   (redirect),
        .mem_op     (mem_op),
        .mem_done   (mem_done),
        .load_data  (load_data)
    );

    load_store_unit load_store_unit_i (
        .clk        (clk),
        .reset      (reset),
        .mem_op     (mem_op),
        .mem_done   (mem_done),
        .load_data  (load_data),
        .data_req   (data_req),
        .data_rsp   (data_rsp)
    );

    bus_arbiter bus_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .data_req   (data_req),
        .data_rsp   (data_rsp),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp)
    );

endmodule

/* dv/bus_checker.sv */
`timescale 1ns/1ps

module bus_checker (
    input logic            clk,
    input logic            reset,
    input rv_pkg::wb_req_t bus_req,
    input rv_pkg::wb_rsp_t bus_rsp
);

    int fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        bus_req.stb |-> bus_req.cyc)
    else begin
        $error("stb high without cyc");
        fail_count++;
    end

    // request held from stb until ack
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (bus_req.stb && !bus_rsp.ack) |=> $stable(bus_req))
    else begin
        $error("bus request changed before ack");
        fail_count++;
    end

    no_cyc_in_reset: assert property (@(posedge clk)
        reset |=> !bus_req.cyc)
    else begin
        $error("cyc high during or right after reset");
        fail_count++;
    end

endmodule

bind core_top bus_checker bus_checker_i (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
);

/* dv/store_monitor.sv */
`timescale 1ns/1ps

module store_monitor (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::wb_req_t bus_req,
    input  rv_pkg::wb_rsp_t bus_rsp,
    output int              checked,
    output int              expected,
    output int              errors,
    output logic            done
);

    localparam int td_words = 192;

    logic [31:0] td [td_words];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int n_checked = 0;
    int n_expected = 0;
    int n_errors = 0;
    bit fetch_seen = 1'b0;

    assign checked = n_checked;
    assign expected = n_expected;
    assign errors = n_errors;
    assign done = (n_expected > 0) && (n_checked >= n_expected);

    initial begin : load_expected
        int k;
        $readmemh("dv/core_testdata.txt", td);
        k = 0;
        while (k + 2 < td_words && (td[k] === 32'd1 || td[k] === 32'd2)) begin
            if (td[k] === 32'd2) begin
                exp_adr.push_back(td[k+1]);
                exp_dat.push_back(td[k+2]);
            end
            k += 3;
        end
        n_expected = exp_adr.size();
    end

    // mid-cycle sampling where bus and ack are settled
    always @(negedge clk) begin
        if (!reset && bus_req.cyc && bus_req.stb && !fetch_seen) begin
            fetch_seen = 1'b1;
            if (bus_req.we || bus_req.adr !== rv_pkg::reset_pc) begin
                $display("** Error at %0t: first bus cycle at %h, expected a fetch from %h",
                         $time, bus_req.adr, rv_pkg::reset_pc);
                n_errors++;
            end
        end
        if (!reset && bus_req.cyc && bus_req.stb && bus_req.we && bus_rsp.ack) begin
            if (n_checked >= n_expected) begin
                $display("** Error at %0t: unexpected write of %h to %h",
                         $time, bus_req.dat_w, bus_req.adr);
                n_errors++;
            end else begin
                if (bus_req.adr !== exp_adr[n_checked] ||
                    bus_req.dat_w !== exp_dat[n_checked]) begin
                    $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, n_checked, bus_req.dat_w, bus_req.adr,
                             exp_dat[n_checked], exp_adr[n_checked]);
                    n_errors++;
                end else begin
                    $display("store %0d: %h to %h ok", n_checked, bus_req.dat_w, bus_req.adr);
                end
                n_checked++;
            end
        end
    end

endmodule

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int mem_words = 256;
    localparam int td_words = 192;
    localparam int run_timeout = 5000;
    localparam int idle_limit = 100;
    localparam int drain_cycles = 200;

    logic clk;
    logic reset;
    rv_pkg::wb_req_t bus_req;
    rv_pkg::wb_rsp_t bus_rsp;

    logic [31:0] mem [mem_words];
    logic [31:0] td [td_words];
    integer seed;
    bit model_failed;
    int checked;
    int expected;
    int errors;
    logic stores_done;

    core_top core_top_i (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    store_monitor store_monitor_i (
        .clk      (clk),
        .reset    (reset),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .checked  (checked),
        .expected (expected),
        .errors   (errors),
        .done     (stores_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // program records only, the monitor takes the store records
    task automatic load_program();
        int k;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hdead_0000 ^ (i << 2);
        end
        $readmemh("dv/core_testdata.txt", td);
        k = 0;
        while (k + 2 < td_words && (td[k] === 32'd1 || td[k] === 32'd2)) begin
            if (td[k] === 32'd1) begin
                mem[td[k+1][9:2]] = td[k+2];
            end
            k += 3;
        end
    endtask

    // sampled 1 ns into the cycle
    task automatic wait_request(output bit seen);
        int idle;
        idle = 0;
        while (!(bus_req.cyc && bus_req.stb) && idle < idle_limit) begin
            @(posedge clk);
            #1;
            idle++;
        end
        seen = bus_req.cyc && bus_req.stb;
    endtask

    task automatic answer_request();
        int waits;
        waits = $random(seed) & 3;
        repeat (waits) begin
            @(posedge clk);
            #1;
        end
        if (bus_req.we) begin
            mem[bus_req.adr[9:2]] = bus_req.dat_w;
            bus_rsp.dat_r = '0;
        end else begin
            bus_rsp.dat_r = mem[bus_req.adr[9:2]];
        end
        bus_rsp.ack = 1'b1;
        @(posedge clk);
        #1;
        bus_rsp.ack = 1'b0;
    endtask

    task automatic report_and_finish();
        int asserts;
        asserts = core_top_i.bus_checker_i.fail_count;
        $display("stores checked %0d of %0d, errors %0d, assertion failures %0d",
                 checked, expected, errors, asserts);
        if (errors == 0 && asserts == 0 && stores_done && !model_failed) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin : memory_model
        bit req_seen;
        @(negedge reset);
        req_seen = 1'b1;
        while (req_seen) begin
            wait_request(req_seen);
            if (req_seen) begin
                answer_request();
            end
        end
        $display("memory model saw no bus request for %0d cycles", idle_limit);
        model_failed = 1'b1;
        report_and_finish();
    end

    initial begin : main
        int cycles;
        seed = 32'ha2c8_baf0;
        model_failed = 1'b0;
        reset = 1'b1;
        bus_rsp = '0;
        load_program();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        cycles = 0;
        while (!stores_done && cycles < run_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!stores_done) begin
            $display("only %0d of %0d expected stores appeared within %0d cycles",
                     checked, expected, run_timeout);
        end
        // core spins on its last jal so any write now is a stray
        repeat (drain_cycles) @(posedge clk);
        report_and_finish();
    end

endmodule

/* dv/core_testdata.txt */
// kind addr data, kind 1 = program word, kind 2 = expected store in order
// kind 0 ends the list
1 00000000 00500093 // addi x1, x0, 5
1 00000004 00C00113 // addi x2, x0, 12
1 00000008 002081B3
1 0000000C 40208233
1 00000010 0020F2B3
1 00000014 0020E333
1 00000018 0020C3B3
1 0000001C 12345437 // lui x8, 0x12345
1 00000020 10302023
1 00000024 10402223
1 00000028 10502423
1 0000002C 10602623
1 00000030 10702823
1 00000034 10802A23
1 00000038 10402503 // lw x10, 0x104(x0)
1 0000003C 10A02C23
1 00000040 0F002583 // lw x11, 0x0f0(x0)
1 00000044 10B02E23
1 00000048 00700013 // addi x0, x0, 7
1 0000004C 12002023
1 00000050 00208463 // beq not taken
1 00000054 12102223
1 00000058 00209463 // bne taken
1 0000005C 12202423
1 00000060 00108463 // beq taken
1 00000064 12202623
1 00000068 00109463 // bne not taken
1 0000006C 12202823
1 00000070 0080066F // jal x12, +8
1 00000074 12202A23
1 00000078 12C02C23
1 0000007C 0000006F // jal x0, 0
1 000000F0 CAFEF00D
2 00000100 00000011
2 00000104 FFFFFFF9
2 00000108 00000004
2 0000010C 0000000D
2 00000110 00000009
2 00000114 12345000
2 00000118 FFFFFFF9
2 0000011C CAFEF00D
2 00000120 00000000
2 00000124 00000005
2 00000130 0000000C
2 00000138 00000074
0 00000000 00000000

/* all.f */
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/core_top.sv
dv/bus_checker.sv
dv/store_monitor.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/reg_file.sv
  - logic/fetch_unit.sv
  - logic/exec_unit.sv
  - logic/load_store_unit.sv
  - logic/bus_arbiter.sv
  - logic/core_top.sv
  - target: test
    files:
      - dv/bus_checker.sv
      - dv/store_monitor.sv
      - dv/core_tb.sv
